// ==== all.f ====
regReadPkg.sv
issueLaneIf.sv
physRegFile.sv
operandBypass.sv
squashLatch.sv
readyTable.sv
regReadStage.sv
tbClkGen.sv
tbRegReadStage.sv

// ==== tbRegReadStage.sv ====
`default_nettype none

module tbRegReadStage;
  timeunit 1ns;
  timeprecision 100ps;
  import regReadPkg::*;

  localparam int RESET_CYCLES  = 5;
  localparam int TIMEOUT_SLACK = 20;
  localparam logic [NUM_PHYS-1:0] RDY_RESET = 64'h0000_0000_ffff_ffff;

  // one cycle of inputs plus what the FUs should see a cycle later.
  typedef struct {
    string                          name;
    logic          [NUM_LANES-1:0]  valid;
    physTag_t      [NUM_LANES-1:0]  src1;
    physTag_t      [NUM_LANES-1:0]  src2;
    ckptMask_t     [NUM_LANES-1:0]  mask;
    issuePayload_t [NUM_LANES-1:0]  payload;
    wbPort_t       [NUM_LANES-1:0]  wb;
    tagPort_t      [NUM_LANES-1:0]  unmap;
    tagPort_t      [NUM_LANES-1:0]  wakeup;
    logic                           verified;
    logic                           mispredict;
    ckptId_t                        ckpt;
    logic                           exception;
    logic          [NUM_LANES-1:0]  expValid;
    operand_t      [NUM_LANES-1:0]  expSrc1;
    operand_t      [NUM_LANES-1:0]  expSrc2;
    logic          [NUM_PHYS-1:0]   expRdy;
  } tableRow_t;

  logic                           clk;
  logic                           rst;
  logic          [NUM_LANES-1:0]  issueValid;
  physTag_t      [NUM_LANES-1:0]  issueSrc1;
  physTag_t      [NUM_LANES-1:0]  issueSrc2;
  ckptMask_t     [NUM_LANES-1:0]  issueMask;
  issuePayload_t [NUM_LANES-1:0]  issuePayload;
  wbPort_t       [NUM_LANES-1:0]  wb;
  tagPort_t      [NUM_LANES-1:0]  unmap;
  tagPort_t      [NUM_LANES-1:0]  wakeup;
  logic                           ctrlVerified;
  logic                           ctrlMispredict;
  ckptId_t                        ctrlCkpt;
  logic                           exceptionFlag;
  logic          [NUM_LANES-1:0]  fuValid;
  operand_t      [NUM_LANES-1:0]  fuSrc1Data;
  operand_t      [NUM_LANES-1:0]  fuSrc2Data;
  issuePayload_t [NUM_LANES-1:0]  fuPayload;
  logic          [NUM_PHYS-1:0]   phyRegRdy;

  tableRow_t rows[$];
  tableRow_t cur;
  integer    seed;
  int        cycleCount = 0;

  tbClkGen #(
    .PERIOD_NS (4)
  ) u_clkGen (
    .clk_o (clk)
  );

  regReadStage #(
    .NUM_LANES (NUM_LANES),
    .NUM_ARCH  (NUM_ARCH)
  ) u_dut (
    .clk              (clk),
    .rst_i            (rst),
    .issueValid_i     (issueValid),
    .issueSrc1_i      (issueSrc1),
    .issueSrc2_i      (issueSrc2),
    .issueMask_i      (issueMask),
    .issuePayload_i   (issuePayload),
    .wb_i             (wb),
    .unmap_i          (unmap),
    .wakeup_i         (wakeup),
    .ctrlVerified_i   (ctrlVerified),
    .ctrlMispredict_i (ctrlMispredict),
    .ctrlCkpt_i       (ctrlCkpt),
    .exceptionFlag_i  (exceptionFlag),
    .fuValid_o        (fuValid),
    .fuSrc1Data_o     (fuSrc1Data),
    .fuSrc2Data_o     (fuSrc2Data),
    .fuPayload_o      (fuPayload),
    .phyRegRdy_o      (phyRegRdy)
  );

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic checkValid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abortRun($sformatf("Error %s: expected %b, actual %b", name, exp, act));
    end
  endtask

  task automatic checkOperand(input string name, input operand_t exp, input operand_t act);
    if (act !== exp) begin
      abortRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkPayload(input string name, input issuePayload_t exp,
                              input issuePayload_t act);
    if (act !== exp) begin
      abortRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic checkReady(input string name, input logic [NUM_PHYS-1:0] exp,
                            input logic [NUM_PHYS-1:0] act);
    if (act !== exp) begin
      abortRun($sformatf("Error %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  // row builders.
  task automatic newRow(input string name);
    cur.name       = name;
    cur.valid      = '0;
    cur.src1       = '0;
    cur.src2       = '0;
    cur.mask       = '0;
    cur.payload    = '0;
    cur.wb         = '0;
    cur.unmap      = '0;
    cur.wakeup     = '0;
    cur.verified   = 1'b0;
    cur.mispredict = 1'b0;
    cur.ckpt       = '0;
    cur.exception  = 1'b0;
    cur.expValid   = '0;
    cur.expSrc1    = '0;
    cur.expSrc2    = '0;
  endtask

  task automatic issueLane(input int l, input int s1, input int s2, input ckptMask_t m,
                           input logic expV, input operand_t e1, input operand_t e2);
    cur.valid[l]    = 1'b1;
    cur.src1[l]     = physTag_t'(s1);
    cur.src2[l]     = physTag_t'(s2);
    cur.mask[l]     = m;
    cur.expValid[l] = expV;
    cur.expSrc1[l]  = e1;
    cur.expSrc2[l]  = e2;
  endtask

  task automatic writeBack(input int l, input int tag, input operand_t data);
    cur.wb[l].valid = 1'b1;
    cur.wb[l].tag   = physTag_t'(tag);
    cur.wb[l].data  = data;
  endtask

  task automatic unmapTag(input int l, input int tag);
    cur.unmap[l].valid = 1'b1;
    cur.unmap[l].tag   = physTag_t'(tag);
  endtask

  task automatic wakeTag(input int l, input int tag);
    cur.wakeup[l].valid = 1'b1;
    cur.wakeup[l].tag   = physTag_t'(tag);
  endtask

  task automatic branchResult(input logic v, input logic m, input int c);
    cur.verified   = v;
    cur.mispredict = m;
    cur.ckpt       = ckptId_t'(c);
  endtask

  // lane l reads tag 40+l (d0d0 data) and 48+l (c0c0 data).
  task automatic issueSquashSet(input ckptMask_t [NUM_LANES-1:0] masks,
                                input logic [NUM_LANES-1:0] expV);
    for (int l = 0; l < NUM_LANES; l++) begin
      issueLane(l, 40 + l, 48 + l, masks[l], expV[l], 32'hd0d0_0000 + l, 32'hc0c0_0000 + l);
    end
  endtask

  task automatic endRow(input logic [NUM_PHYS-1:0] rdy);
    for (int l = 0; l < NUM_LANES; l++) begin
      cur.payload[l] = issuePayload_t'($random(seed));
    end
    cur.expRdy = rdy;
    rows.push_back(cur);
  endtask

  task automatic buildTable();
    newRow("fileFill");
    for (int l = 0; l < NUM_LANES; l++) begin
      writeBack(l, 40 + l, 32'ha0a0_0000 + l);
    end
    endRow(RDY_RESET);

    // back-to-back reads while the next group is written.
    newRow("readBack0");
    for (int l = 0; l < NUM_LANES; l++) begin
      issueLane(l, 40 + l, 43 - l, 4'b0000, 1'b1, 32'ha0a0_0000 + l, 32'ha0a0_0003 - l);
      writeBack(l, 44 + l, 32'hb0b0_0000 + l);
    end
    endRow(RDY_RESET);
    newRow("readBack1");
    for (int l = 0; l < NUM_LANES; l++) begin
      issueLane(l, 44 + l, 40 + l, 4'b0000, 1'b1, 32'hb0b0_0000 + l, 32'ha0a0_0000 + l);
      writeBack(l, 48 + l, 32'hc0c0_0000 + l);
    end
    endRow(RDY_RESET);
    newRow("readBack2");
    for (int l = 0; l < NUM_LANES; l++) begin
      issueLane(l, 48 + l, 47 - l, 4'b0000, 1'b1, 32'hc0c0_0000 + l, 32'hb0b0_0003 - l);
    end
    endRow(RDY_RESET);

    // same-cycle forwarding from each writeback lane.
    newRow("fwdLane0");
    issueLane(0, 40, 41, 4'b0000, 1'b1, 32'hd0d0_0000, 32'ha0a0_0001);
    writeBack(0, 40, 32'hd0d0_0000);
    endRow(RDY_RESET);
    newRow("fwdLane1");
    issueLane(1, 41, 42, 4'b0000, 1'b1, 32'hd0d0_0001, 32'ha0a0_0002);
    writeBack(1, 41, 32'hd0d0_0001);
    endRow(RDY_RESET);
    newRow("fwdLane2");
    issueLane(2, 42, 40, 4'b0000, 1'b1, 32'hd0d0_0002, 32'hd0d0_0000);
    writeBack(2, 42, 32'hd0d0_0002);
    endRow(RDY_RESET);
    newRow("fwdLane3");
    issueLane(3, 43, 41, 4'b0000, 1'b1, 32'hd0d0_0003, 32'hd0d0_0001);
    writeBack(3, 43, 32'hd0d0_0003);
    endRow(RDY_RESET);
    newRow("fwdSplit");
    issueLane(0, 44, 45, 4'b0000, 1'b1, 32'he0e0_0000, 32'he0e0_0001);
    issueLane(2, 46, 44, 4'b0000, 1'b1, 32'hb0b0_0002, 32'he0e0_0000);
    writeBack(1, 44, 32'he0e0_0000);
    writeBack(2, 45, 32'he0e0_0001);
    endRow(RDY_RESET);

    // squash on checkpoint hits only.
    newRow("squashCkpt2");
    issueSquashSet({4'b0000, 4'b1100, 4'b0011, 4'b0100}, 4'b1010);
    branchResult(1'b1, 1'b1, 2);
    endRow(RDY_RESET);
    newRow("unverified");
    issueSquashSet({4'b0000, 4'b1100, 4'b0011, 4'b0100}, 4'b1111);
    branchResult(1'b0, 1'b1, 2);
    endRow(RDY_RESET);
    newRow("maskMiss");
    issueSquashSet({4'b0001, 4'b1000, 4'b0010, 4'b0001}, 4'b1111);
    branchResult(1'b1, 1'b1, 2);
    endRow(RDY_RESET);
    newRow("squashCkpt0");
    issueSquashSet({4'b0000, 4'b1001, 4'b0010, 4'b0001}, 4'b1010);
    branchResult(1'b1, 1'b1, 0);
    endRow(RDY_RESET);
    newRow("resolvedOk");
    issueSquashSet({4'b0000, 4'b1001, 4'b0010, 4'b0001}, 4'b1111);
    branchResult(1'b1, 1'b0, 0);
    endRow(RDY_RESET);

    // ready table updates.
    newRow("unmapClear");
    unmapTag(0, 3);
    unmapTag(2, 20);
    endRow(64'h0000_0000_ffef_fff7);
    newRow("wakeupSet");
    wakeTag(1, 40);
    wakeTag(3, 63);
    endRow(64'h8000_0100_ffef_fff7);
    newRow("wakeupWins");
    unmapTag(1, 40);
    wakeTag(2, 40);
    unmapTag(3, 5);
    wakeTag(0, 3);
    endRow(64'h8000_0100_ffef_ffdf);
    newRow("exceptionPreset");
    cur.exception = 1'b1;
    wakeTag(0, 50);
    issueLane(0, 40, 41, 4'b0000, 1'b1, 32'hd0d0_0000, 32'hd0d0_0001);
    endRow(RDY_RESET);
    newRow("idle");
    endRow(RDY_RESET);
  endtask

  task automatic applyRow(input tableRow_t r);
    issueValid     <= r.valid;
    issueSrc1      <= r.src1;
    issueSrc2      <= r.src2;
    issueMask      <= r.mask;
    issuePayload   <= r.payload;
    wb             <= r.wb;
    unmap          <= r.unmap;
    wakeup         <= r.wakeup;
    ctrlVerified   <= r.verified;
    ctrlMispredict <= r.mispredict;
    ctrlCkpt       <= r.ckpt;
    exceptionFlag  <= r.exception;
  endtask

  task automatic applyIdle();
    issueValid     <= '0;
    wb             <= '0;
    unmap          <= '0;
    wakeup         <= '0;
    ctrlVerified   <= 1'b0;
    ctrlMispredict <= 1'b0;
    exceptionFlag  <= 1'b0;
  endtask

  task automatic checkRow(input tableRow_t r);
    for (int l = 0; l < NUM_LANES; l++) begin
      checkValid($sformatf("%s lane%0d valid", r.name, l), r.expValid[l], fuValid[l]);
      if (r.expValid[l]) begin
        checkOperand($sformatf("%s lane%0d src1", r.name, l), r.expSrc1[l], fuSrc1Data[l]);
        checkOperand($sformatf("%s lane%0d src2", r.name, l), r.expSrc2[l], fuSrc2Data[l]);
      end
      if (r.valid[l]) begin
        checkPayload($sformatf("%s lane%0d payload", r.name, l), r.payload[l], fuPayload[l]);
      end
    end
    checkReady($sformatf("%s ready", r.name), r.expRdy, phyRegRdy);
  endtask

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= RESET_CYCLES + rows.size() + TIMEOUT_SLACK) begin
      abortRun("run timed out before all table rows were checked");
    end
  end

  initial begin
    seed           = 32'h1694fc5c;
    rst            = 1'b1;
    // every lane issues while reset is held.
    issueValid     = '1;
    issueSrc1      = '0;
    issueSrc2      = '0;
    issueMask      = '0;
    issuePayload   = '0;
    wb             = '0;
    unmap          = '0;
    wakeup         = '0;
    ctrlVerified   = 1'b0;
    ctrlMispredict = 1'b0;
    ctrlCkpt       = '0;
    exceptionFlag  = 1'b0;
    buildTable();

    repeat (RESET_CYCLES) @(posedge clk);
    rst        <= 1'b0;
    issueValid <= '0;
    @(negedge clk);
    for (int l = 0; l < NUM_LANES; l++) begin
      checkValid($sformatf("reset lane%0d valid", l), 1'b0, fuValid[l]);
    end
    checkReady("reset ready", RDY_RESET, phyRegRdy);

    // row i goes in while row i-1 comes out.
    for (int i = 0; i <= rows.size(); i++) begin
      @(posedge clk);
      if (i < rows.size()) begin
        applyRow(rows[i]);
      end else begin
        applyIdle();
      end
      @(negedge clk);
      if (i > 0) begin
        checkRow(rows[i-1]);
      end
    end

    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tbClkGen.sv ====
`default_nettype none

module tbClkGen #(
  parameter int PERIOD_NS = 4
) (
  output logic clk_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // free-running, starts low.
  initial begin
    clk_o = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end
  end

endmodule

`default_nettype wire

// ==== regReadStage.sv ====
`default_nettype none

module regReadStage #(
  parameter int NUM_LANES = regReadPkg::NUM_LANES,
  parameter int NUM_ARCH  = regReadPkg::NUM_ARCH
) (
  input  wire                                            clk,
  input  wire                                            rst_i,
  input  wire                           [NUM_LANES-1:0]  issueValid_i,
  input  wire regReadPkg::physTag_t      [NUM_LANES-1:0] issueSrc1_i,
  input  wire regReadPkg::physTag_t      [NUM_LANES-1:0] issueSrc2_i,
  input  wire regReadPkg::ckptMask_t     [NUM_LANES-1:0] issueMask_i,
  input  wire regReadPkg::issuePayload_t [NUM_LANES-1:0] issuePayload_i,
  input  wire regReadPkg::wbPort_t       [NUM_LANES-1:0] wb_i,
  input  wire regReadPkg::tagPort_t      [NUM_LANES-1:0] unmap_i,
  input  wire regReadPkg::tagPort_t      [NUM_LANES-1:0] wakeup_i,
  input  wire                                            ctrlVerified_i,
  input  wire                                            ctrlMispredict_i,
  input  wire regReadPkg::ckptId_t                       ctrlCkpt_i,
  input  wire                                            exceptionFlag_i,
  output wire                           [NUM_LANES-1:0]  fuValid_o,
  output wire regReadPkg::operand_t      [NUM_LANES-1:0] fuSrc1Data_o,
  output wire regReadPkg::operand_t      [NUM_LANES-1:0] fuSrc2Data_o,
  output wire regReadPkg::issuePayload_t [NUM_LANES-1:0] fuPayload_o,
  output wire [regReadPkg::NUM_PHYS-1:0]                 phyRegRdy_o
);
  import regReadPkg::*;

  wire physTag_t [2*NUM_LANES-1:0] rdTag;
  wire operand_t [2*NUM_LANES-1:0] fileData;
  wire operand_t [NUM_LANES-1:0]   src1Data;
  wire operand_t [NUM_LANES-1:0]   src2Data;

  issueLaneIf laneIf [NUM_LANES] ();

  // fan the flat issue ports into lanes.
  for (genvar i = 0; i < NUM_LANES; i++) begin : gIssue
    assign laneIf[i].valid   = issueValid_i[i];
    assign laneIf[i].src1    = issueSrc1_i[i];
    assign laneIf[i].src2    = issueSrc2_i[i];
    assign laneIf[i].mask    = issueMask_i[i];
    assign laneIf[i].payload = issuePayload_i[i];
  end

  physRegFile #(
    .NUM_LANES (NUM_LANES)
  ) u_regFile (
    .clk      (clk),
    .wb_i     (wb_i),
    .rdTag_i  (rdTag),
    .rdData_o (fileData)
  );

  operandBypass #(
    .NUM_LANES (NUM_LANES)
  ) u_bypass (
    .lane       (laneIf),
    .wb_i       (wb_i),
    .fileData_i (fileData),
    .rdTag_o    (rdTag),
    .src1Data_o (src1Data),
    .src2Data_o (src2Data)
  );

  squashLatch #(
    .NUM_LANES (NUM_LANES)
  ) u_squash (
    .clk              (clk),
    .rst_i            (rst_i),
    .lane             (laneIf),
    .src1Data_i       (src1Data),
    .src2Data_i       (src2Data),
    .ctrlVerified_i   (ctrlVerified_i),
    .ctrlMispredict_i (ctrlMispredict_i),
    .ctrlCkpt_i       (ctrlCkpt_i),
    .fuValid_o        (fuValid_o),
    .fuSrc1Data_o     (fuSrc1Data_o),
    .fuSrc2Data_o     (fuSrc2Data_o),
    .fuPayload_o      (fuPayload_o)
  );

  // scoreboard for the issue queue.
  readyTable #(
    .NUM_LANES (NUM_LANES),
    .NUM_ARCH  (NUM_ARCH)
  ) u_ready (
    .clk             (clk),
    .rst_i           (rst_i),
    .exceptionFlag_i (exceptionFlag_i),
    .unmap_i         (unmap_i),
    .wakeup_i        (wakeup_i),
    .phyRegRdy_o     (phyRegRdy_o)
  );

endmodule

`default_nettype wire

// ==== readyTable.sv ====
`default_nettype none

module readyTable #(
  parameter int NUM_LANES = regReadPkg::NUM_LANES,
  parameter int NUM_ARCH  = regReadPkg::NUM_ARCH
) (
  input  wire                                       clk,
  input  wire                                       rst_i,
  input  wire                                       exceptionFlag_i,
  input  wire regReadPkg::tagPort_t [NUM_LANES-1:0] unmap_i,
  input  wire regReadPkg::tagPort_t [NUM_LANES-1:0] wakeup_i,
  output logic [regReadPkg::NUM_PHYS-1:0]           phyRegRdy_o
);
  import regReadPkg::*;

  logic [NUM_PHYS-1:0] nextRdy;
  logic                tagActive;

  // clears first, then sets.
  always_comb begin
    nextRdy = phyRegRdy_o;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (unmap_i[l].valid) begin
        nextRdy[unmap_i[l].tag] = 1'b0;
      end
    end
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wakeup_i[l].valid) begin
        nextRdy[wakeup_i[l].tag] = 1'b1;
      end
    end
  end

  // initial mappings ready, free list not.
  always_ff @(posedge clk) begin
    if (rst_i || exceptionFlag_i) begin
      for (int p = 0; p < NUM_PHYS; p++) begin
        phyRegRdy_o[p] <= (p < NUM_ARCH);
      end
    end else begin
      phyRegRdy_o <= nextRdy;
    end
  end

  always_comb begin
    tagActive = 1'b0;
    for (int l = 0; l < NUM_LANES; l++) begin
      tagActive = tagActive | unmap_i[l].valid | wakeup_i[l].valid;
    end
  end

  // rename and the scheduler stay idle during reset.
  idleInReset: assert property (@(posedge clk) rst_i |-> !tagActive)
    else $error("tag update during reset");

endmodule

`default_nettype wire

// ==== squashLatch.sv ====
`default_nettype none

module squashLatch #(
  parameter int NUM_LANES = regReadPkg::NUM_LANES
) (
  input  wire                                             clk,
  input  wire                                             rst_i,
  issueLaneIf.consumer                                    lane [NUM_LANES],
  input  wire regReadPkg::operand_t      [NUM_LANES-1:0]  src1Data_i,
  input  wire regReadPkg::operand_t      [NUM_LANES-1:0]  src2Data_i,
  input  wire                                             ctrlVerified_i,
  input  wire                                             ctrlMispredict_i,
  input  wire regReadPkg::ckptId_t                        ctrlCkpt_i,
  output logic                           [NUM_LANES-1:0]  fuValid_o,
  output regReadPkg::operand_t           [NUM_LANES-1:0]  fuSrc1Data_o,
  output regReadPkg::operand_t           [NUM_LANES-1:0]  fuSrc2Data_o,
  output regReadPkg::issuePayload_t      [NUM_LANES-1:0]  fuPayload_o
);
  import regReadPkg::*;

  wire                                mispredict;
  wire                [NUM_LANES-1:0] keepValid;
  wire issuePayload_t [NUM_LANES-1:0] lanePayload;

  // resolved branch that went the wrong way.
  assign mispredict = ctrlVerified_i & ctrlMispredict_i;

  for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
    // drop lanes sitting on the bad checkpoint.
    assign keepValid[i]   = lane[i].valid & ~(mispredict & lane[i].mask[ctrlCkpt_i]);
    assign lanePayload[i] = lane[i].payload;
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      fuValid_o <= '0;
    end else begin
      fuValid_o <= keepValid;
    end
  end

  // data side of the pipeline register.
  always_ff @(posedge clk) begin
    fuSrc1Data_o <= src1Data_i;
    fuSrc2Data_o <= src2Data_i;
    fuPayload_o  <= lanePayload;
  end

  // nothing leaves toward the FUs right after reset.
  quietAfterReset: assert property (@(posedge clk) rst_i |=> (fuValid_o == '0))
    else $error("valid output after reset");

endmodule

`default_nettype wire

// ==== operandBypass.sv ====
`default_nettype none

module operandBypass #(
  parameter int NUM_LANES = regReadPkg::NUM_LANES
) (
  issueLaneIf.consumer                                lane [NUM_LANES],
  input  wire regReadPkg::wbPort_t  [NUM_LANES-1:0]   wb_i,
  input  wire regReadPkg::operand_t [2*NUM_LANES-1:0] fileData_i,
  output wire regReadPkg::physTag_t [2*NUM_LANES-1:0] rdTag_o,
  output wire regReadPkg::operand_t [NUM_LANES-1:0]   src1Data_o,
  output wire regReadPkg::operand_t [NUM_LANES-1:0]   src2Data_o
);
  import regReadPkg::*;

  // walk from the top lane down so the lowest match is applied last.
  function automatic operand_t forward(
    input physTag_t                 tag,
    input operand_t                 fileVal,
    input wbPort_t [NUM_LANES-1:0]  wb
  );
    operand_t result;
    result = fileVal;
    for (int k = NUM_LANES - 1; k >= 0; k--) begin
      if (wb[k].valid && (wb[k].tag == tag)) begin
        result = wb[k].data;
      end
    end
    return result;
  endfunction

  for (genvar i = 0; i < NUM_LANES; i++) begin : gLane
    // file read addresses.
    assign rdTag_o[2*i]     = lane[i].src1;
    assign rdTag_o[2*i + 1] = lane[i].src2;

    // results finishing this cycle beat the stale file copy.
    assign src1Data_o[i] = forward(lane[i].src1, fileData_i[2*i], wb_i);
    assign src2Data_o[i] = forward(lane[i].src2, fileData_i[2*i + 1], wb_i);
  end

endmodule

`default_nettype wire

// ==== physRegFile.sv ====
`default_nettype none

module physRegFile #(
  parameter int NUM_LANES = regReadPkg::NUM_LANES
) (
  input  wire                                        clk,
  input  wire regReadPkg::wbPort_t  [NUM_LANES-1:0]   wb_i,
  input  wire regReadPkg::physTag_t [2*NUM_LANES-1:0] rdTag_i,
  output regReadPkg::operand_t      [2*NUM_LANES-1:0] rdData_o
);
  import regReadPkg::*;

  operand_t regFile [NUM_PHYS];
  logic     wbConflict;

  // one write port per lane.
  always_ff @(posedge clk) begin
    for (int l = 0; l < NUM_LANES; l++) begin
      if (wb_i[l].valid) begin
        regFile[wb_i[l].tag] <= wb_i[l].data;
      end
    end
  end

  // two read ports per lane, src1 on even index.
  always_comb begin
    for (int r = 0; r < 2 * NUM_LANES; r++) begin
      rdData_o[r] = regFile[rdTag_i[r]];
    end
  end

  // any two valid writebacks aimed at one register.
  always_comb begin
    wbConflict = 1'b0;
    for (int a = 0; a < NUM_LANES; a++) begin
      for (int b = a + 1; b < NUM_LANES; b++) begin
        if (wb_i[a].valid && wb_i[b].valid && (wb_i[a].tag == wb_i[b].tag)) begin
          wbConflict = 1'b1;
        end
      end
    end
  end

  // rename never hands out one tag to two in-flight producers.
  wbDistinct: assert property (@(posedge clk) !wbConflict)
    else $error("writeback destinations collide");

endmodule

`default_nettype wire

// ==== issueLaneIf.sv ====
`default_nettype none

interface issueLaneIf;
  import regReadPkg::*;

  logic          valid;
  physTag_t      src1;
  physTag_t      src2;
  ckptMask_t     mask;
  issuePayload_t payload;

  // issue side.
  modport producer (
    output valid,
    output src1,
    output src2,
    output mask,
    output payload
  );

  // read stage side.
  modport consumer (
    input valid,
    input src1,
    input src2,
    input mask,
    input payload
  );

endinterface

`default_nettype wire

// ==== regReadPkg.sv ====
`default_nettype none

package regReadPkg;

  // machine sizing.
  localparam int NUM_LANES = 4;
  localparam int NUM_PHYS  = 64;
  localparam int NUM_ARCH  = 32;
  localparam int DATA_W    = 32;
  localparam int CKPT_NUM  = 4;

  localparam int PHYS_W    = $clog2(NUM_PHYS);
  localparam int CKPT_W    = $clog2(CKPT_NUM);
  localparam int PAYLOAD_W = 24;

  typedef logic [PHYS_W-1:0]    physTag_t;
  typedef logic [CKPT_W-1:0]    ckptId_t;
  typedef logic [CKPT_NUM-1:0]  ckptMask_t;
  typedef logic [DATA_W-1:0]    operand_t;

  // iq id, lsq id, al id, imm, opcode, pcs and cti, carried untouched.
  typedef logic [PAYLOAD_W-1:0] issuePayload_t;

  // one result bus from a functional unit.
  typedef struct packed {
    logic     valid;
    physTag_t tag;
    operand_t data;
  } wbPort_t;

  // unmap and wakeup share this shape.
  typedef struct packed {
    logic     valid;
    physTag_t tag;
  } tagPort_t;

endpackage

`default_nettype wire
